// File: project.f
+incdir+source
source/obi_pkg.sv
source/obi_addr_decode.sv
source/obi_rr_arbiter.sv
source/obi_xbar.sv
source/obi_sram_target.sv
source/obi_error_target.sv
source/system_bus.sv
tests/system_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module system_bus_tb \
  || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/Vsystem_bus_tb 2>&1)"
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' \
  && { echo "Simulation result: pass"; exit 0; } \
  || { echo "Simulation result: fail"; exit 1; }

// File: tests/system_bus_tb.sv
// Directed testbench for the system interconnect
// Drives all master ports and checks every response against a byte-level memory model
`timescale 1ns/1ps
`include "obi_settings.svh"

module system_bus_tb;
  import obi_pkg::*;

  logic clk;
  logic rst_n;
  obi_req_t  [`OBI_NMASTER-1:0] mst_req;
  obi_resp_t [`OBI_NMASTER-1:0] mst_resp;

  // Reference bytes of both banks
  logic [7:0] ref_mem [2][`OBI_SRAM_WORDS*4];

  // Per master: pending operations and the response it waits for
  obi_req_t op_q    [`OBI_NMASTER][$];
  logic     granted [`OBI_NMASTER];
  logic     rv_due  [`OBI_NMASTER];
  logic     rv_read [`OBI_NMASTER];
  data_t    rv_data [`OBI_NMASTER];

  // Grants of the last traffic run, master and cycle
  int log_mst[$];
  int log_cyc[$];

  integer seed;

  system_bus dut_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .mst_req_i (mst_req),
    .mst_resp_o(mst_resp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Bank by the address map, error index when no window claims it
  function automatic int bank_of(input addr_t addr, output int base);
    addr_t lo0;
    addr_t lo1;
    lo0  = addr_t'(`OBI_SRAM0_BASE);
    lo1  = addr_t'(`OBI_SRAM1_BASE);
    base = 0;
    if (addr >= lo0 && addr < lo0 + addr_t'(`OBI_SRAM_SIZE)) begin
      base = int'((addr - lo0) & ~addr_t'(3));
      return 0;
    end else if (addr >= lo1 && addr < lo1 + addr_t'(`OBI_SRAM_SIZE)) begin
      base = int'((addr - lo1) & ~addr_t'(3));
      return 1;
    end
    return `OBI_ERROR_IDX;
  endfunction

  function automatic data_t model_read(input addr_t addr);
    int    bank;
    int    base;
    data_t d;
    bank = bank_of(addr, base);
    if (bank == `OBI_ERROR_IDX) begin
      return data_t'(`OBI_ERROR_RDATA);
    end
    for (int b = 0; b < 4; b++) begin
      d[8*b +: 8] = ref_mem[bank][base + b];
    end
    return d;
  endfunction

  task automatic model_write(input obi_req_t op);
    int bank;
    int base;
    bank = bank_of(op.addr, base);
    // Writes to unmapped space vanish
    if (bank != `OBI_ERROR_IDX) begin
      for (int b = 0; b < 4; b++) begin
        if (op.be[b]) begin
          ref_mem[bank][base + b] = op.wdata[8*b +: 8];
        end
      end
    end
  endtask

  // Region 2 is an unmapped window that aliases the bank word index
  function automatic addr_t word_addr(input int region, input int word);
    addr_t base;
    if (region == 0) begin
      base = addr_t'(`OBI_SRAM0_BASE);
    end else if (region == 1) begin
      base = addr_t'(`OBI_SRAM1_BASE);
    end else begin
      base = 32'h0000_2000;
    end
    return base + addr_t'(word * 4);
  endfunction

  function automatic data_t fill_word(input addr_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  task automatic queue_op(input int m, input logic we, input be_t be, input addr_t addr,
                          input data_t wdata);
    obi_req_t op;
    op.req   = 1'b1;
    op.we    = we;
    op.be    = be;
    op.addr  = addr;
    op.wdata = wdata;
    op_q[m].push_back(op);
  endtask

  // Runs all queued operations, checking gnt, rvalid and rdata every cycle
  task automatic run_traffic(input int max_cycles);
    int cyc;
    bit busy;
    cyc  = 0;
    busy = 1'b1;
    log_mst.delete();
    log_cyc.delete();
    while (busy) begin
      if (cyc >= max_cycles) begin
        abort_run($sformatf("Timeout: bus traffic still pending after %0d cycles", cyc));
      end
      @(posedge clk);
      #1;
      for (int m = 0; m < `OBI_NMASTER; m++) begin
        if (granted[m]) begin
          void'(op_q[m].pop_front());
          granted[m] = 1'b0;
        end
        if (op_q[m].size() > 0) begin
          mst_req[m] = op_q[m][0];
        end else begin
          mst_req[m] = '0;
        end
      end
      @(negedge clk);
      busy = 1'b0;
      for (int m = 0; m < `OBI_NMASTER; m++) begin
        check_eq(32'(mst_resp[m].rvalid), 32'(rv_due[m]), $sformatf("master %0d rvalid", m));
        if (rv_due[m] && rv_read[m]) begin
          check_eq(mst_resp[m].rdata, rv_data[m], $sformatf("master %0d rdata", m));
        end
        rv_due[m] = 1'b0;
        if (mst_req[m].req && mst_resp[m].gnt) begin
          granted[m] = 1'b1;
          rv_due[m]  = 1'b1;
          rv_read[m] = !mst_req[m].we;
          if (mst_req[m].we) begin
            model_write(mst_req[m]);
          end else begin
            rv_data[m] = model_read(mst_req[m].addr);
          end
          log_mst.push_back(m);
          log_cyc.push_back(cyc);
        end else if (!mst_req[m].req) begin
          check_eq(32'(mst_resp[m].gnt), 32'd0, $sformatf("master %0d idle gnt", m));
        end
        if (op_q[m].size() > 0 || rv_due[m]) begin
          busy = 1'b1;
        end
      end
      cyc++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n   = 1'b0;
    mst_req = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic test_idle();
    for (int c = 0; c < 8; c++) begin
      @(negedge clk);
      for (int m = 0; m < `OBI_NMASTER; m++) begin
        check_eq(32'(mst_resp[m].gnt), 32'd0, $sformatf("idle gnt of master %0d", m));
        check_eq(32'(mst_resp[m].rvalid), 32'd0, $sformatf("idle rvalid of master %0d", m));
      end
    end
  endtask

  task automatic test_single_master();
    for (int w = 0; w < 4; w++) begin
      queue_op(0, 1'b1, 4'hf, word_addr(0, w), fill_word(word_addr(0, w)));
    end
    // Partial lanes on top of full words
    queue_op(0, 1'b1, 4'b0011, word_addr(0, 1), 32'h1234_5678);
    queue_op(0, 1'b1, 4'b1100, word_addr(0, 2), 32'hcafe_f00d);
    queue_op(0, 1'b1, 4'b0100, word_addr(0, 3), 32'h00aa_0000);
    for (int w = 0; w < 4; w++) begin
      queue_op(0, 1'b0, 4'hf, word_addr(0, w), '0);
    end
    run_traffic(50);
  endtask

  task automatic test_parallel_banks();
    queue_op(0, 1'b1, 4'hf, word_addr(0, 8), 32'h0bad_cafe);
    queue_op(1, 1'b1, 4'hf, word_addr(1, 8), 32'h600d_d00d);
    queue_op(0, 1'b0, 4'hf, word_addr(0, 8), '0);
    queue_op(1, 1'b0, 4'hf, word_addr(1, 8), '0);
    run_traffic(20);
    // Writes side by side in the first cycle, reads side by side in the next
    for (int i = 0; i < 4; i++) begin
      check_eq(32'(log_mst[i]), 32'(i % 2), $sformatf("parallel grant %0d master", i));
      check_eq(32'(log_cyc[i]), 32'(i / 2), $sformatf("parallel grant %0d cycle", i));
    end
  endtask

  task automatic test_round_robin();
    int exp_m;
    for (int w = 16; w < 22; w++) begin
      queue_op(2, 1'b1, 4'hf, word_addr(0, w), fill_word(word_addr(0, w)));
    end
    run_traffic(30);
    // Fresh pointers, so master 0 leads
    apply_reset();
    for (int m = 0; m < `OBI_NMASTER; m++) begin
      queue_op(m, 1'b0, 4'hf, word_addr(0, 16 + m), '0);
      queue_op(m, 1'b0, 4'hf, word_addr(0, 19 + m), '0);
    end
    run_traffic(30);
    // One grant per cycle, rotating from master 0
    exp_m = `OBI_NMASTER - 1;
    for (int i = 0; i < 6; i++) begin
      exp_m = (exp_m + 1) % `OBI_NMASTER;
      check_eq(32'(log_mst[i]), 32'(exp_m), $sformatf("round-robin grant %0d", i));
      check_eq(32'(log_cyc[i]), 32'(i), $sformatf("round-robin grant %0d cycle", i));
    end
  endtask

  task automatic test_unmapped();
    queue_op(1, 1'b1, 4'hf, word_addr(0, 0), 32'h0101_0101);
    queue_op(1, 1'b1, 4'hf, word_addr(1, 1), 32'h0202_0202);
    // Just past each bank and at the top of the space
    queue_op(1, 1'b1, 4'hf, 32'h0000_1000, 32'hdead_0001);
    queue_op(1, 1'b1, 4'hf, 32'h0001_1004, 32'hdead_0002);
    queue_op(1, 1'b1, 4'hf, 32'hffff_fffc, 32'hdead_0003);
    queue_op(1, 1'b0, 4'hf, 32'h0000_1000, '0);
    queue_op(1, 1'b0, 4'hf, 32'h0001_1004, '0);
    queue_op(1, 1'b0, 4'hf, 32'hffff_fffc, '0);
    queue_op(1, 1'b0, 4'hf, word_addr(0, 0), '0);
    queue_op(1, 1'b0, 4'hf, word_addr(1, 1), '0);
    run_traffic(40);
  endtask

  task automatic test_random_traffic();
    logic [31:0] r;
    for (int w = 0; w < 16; w++) begin
      queue_op(0, 1'b1, 4'hf, word_addr(0, w), fill_word(word_addr(0, w)));
      queue_op(0, 1'b1, 4'hf, word_addr(1, w), fill_word(word_addr(1, w)));
    end
    run_traffic(100);
    for (int m = 0; m < `OBI_NMASTER; m++) begin
      for (int n = 0; n < 24; n++) begin
        r = $random(seed);
        queue_op(m, r[16], r[23:20], word_addr(int'(r[1:0]) % 3, int'(r[11:8])), $random(seed));
      end
    end
    run_traffic(1000);
  endtask

  initial begin
    seed    = 32'hc0eb_d186;
    rst_n   = 1'b0;
    mst_req = '0;
    for (int m = 0; m < `OBI_NMASTER; m++) begin
      granted[m] = 1'b0;
      rv_due[m]  = 1'b0;
      rv_read[m] = 1'b0;
      rv_data[m] = '0;
    end
    apply_reset();
    test_idle();
    test_single_master();
    test_parallel_banks();
    test_round_robin();
    test_unmapped();
    test_random_traffic();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: source/system_bus.sv
// Top of the system interconnect
// Three master ports into the crossbar, two SRAM banks and the error target behind it
`timescale 1ns/1ps
`include "obi_settings.svh"

module system_bus (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  obi_pkg::obi_req_t  [`OBI_NMASTER-1:0] mst_req_i,
  output obi_pkg::obi_resp_t [`OBI_NMASTER-1:0] mst_resp_o
);
  import obi_pkg::*;

  obi_req_t  [`OBI_NTARGET-1:0] tgt_req;
  obi_resp_t [`OBI_NTARGET-1:0] tgt_resp;

  obi_xbar xbar_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mst_req_i (mst_req_i),
    .mst_resp_o(mst_resp_o),
    .tgt_req_o (tgt_req),
    .tgt_resp_i(tgt_resp)
  );

  // Bank 0 and bank 1 on target ports 0 and 1
  obi_sram_target sram0_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (tgt_req[0]),
    .resp_o (tgt_resp[0])
  );

  obi_sram_target sram1_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (tgt_req[1]),
    .resp_o (tgt_resp[1])
  );

  obi_error_target error_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (tgt_req[`OBI_ERROR_IDX]),
    .resp_o (tgt_resp[`OBI_ERROR_IDX])
  );

endmodule

// File: source/obi_error_target.sv
// Default target for addresses outside the map
// Accepts everything, drops writes, reads return a fixed pattern
`timescale 1ns/1ps
`include "obi_settings.svh"

module obi_error_target (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  obi_pkg::obi_req_t  req_i,
  output obi_pkg::obi_resp_t resp_o
);
  import obi_pkg::*;

  logic rvalid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = data_t'(`OBI_ERROR_RDATA);

endmodule

// File: source/obi_sram_target.sv
// Single-cycle SRAM bank on an OBI target port
// Grants at once, answers one cycle later, byte-enabled writes
`timescale 1ns/1ps
`include "obi_settings.svh"

module obi_sram_target (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  obi_pkg::obi_req_t  req_i,
  output obi_pkg::obi_resp_t resp_o
);
  import obi_pkg::*;

  localparam int unsigned WORD_AW = $clog2(`OBI_SRAM_WORDS);

  data_t mem [`OBI_SRAM_WORDS];

  // Word index from the in-bank offset
  logic [WORD_AW-1:0] word_idx;
  logic               rvalid_q;
  data_t              rdata_q;

  assign word_idx = req_i.addr[WORD_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  // One response per accepted access, reads and writes alike
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

endmodule

// File: source/obi_xbar.sv
// Full crossbar between the bus masters and the targets
// Decoder per master, round-robin arbiter per target, responses routed back
`timescale 1ns/1ps
`include "obi_settings.svh"

module obi_xbar (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  input  obi_pkg::obi_req_t  [`OBI_NMASTER-1:0]    mst_req_i,
  output obi_pkg::obi_resp_t [`OBI_NMASTER-1:0]    mst_resp_o,

  output obi_pkg::obi_req_t  [`OBI_NTARGET-1:0]    tgt_req_o,
  input  obi_pkg::obi_resp_t [`OBI_NTARGET-1:0]    tgt_resp_i
);
  import obi_pkg::*;

  // Target chosen by each master's address
  tgt_idx_t [`OBI_NMASTER-1:0] dec_idx;

  // Per target: who asks, who wins
  logic [`OBI_NTARGET-1:0][`OBI_NMASTER-1:0] arb_req;
  logic [`OBI_NTARGET-1:0][`OBI_NMASTER-1:0] arb_gnt;
  mst_idx_t [`OBI_NTARGET-1:0]               arb_sel;

  // Accepted transfer per target and the master that owns its response
  logic [`OBI_NTARGET-1:0]     xfer;
  mst_idx_t [`OBI_NTARGET-1:0] owner_q;

  for (genvar m = 0; m < `OBI_NMASTER; m++) begin : gen_decode
    obi_addr_decode decode_i (
      .addr_i(mst_req_i[m].addr),
      .idx_o (dec_idx[m])
    );
  end

  for (genvar t = 0; t < `OBI_NTARGET; t++) begin : gen_target
    for (genvar m = 0; m < `OBI_NMASTER; m++) begin : gen_req
      assign arb_req[t][m] = mst_req_i[m].req && (dec_idx[m] == tgt_idx_t'(t));
    end

    obi_rr_arbiter arb_i (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .req_i  (arb_req[t]),
      .gnt_o  (arb_gnt[t]),
      .sel_o  (arb_sel[t])
    );

    assign xfer[t] = tgt_req_o[t].req && tgt_resp_i[t].gnt;
  end

  // Winner's fields go out as they are, req only if anyone asked
  always_comb begin
    for (int t = 0; t < `OBI_NTARGET; t++) begin
      tgt_req_o[t]     = mst_req_i[arb_sel[t]];
      tgt_req_o[t].req = |arb_req[t];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owner_q <= '0;
    end else begin
      for (int t = 0; t < `OBI_NTARGET; t++) begin
        if (xfer[t]) begin
          owner_q[t] <= arb_sel[t];
        end
      end
    end
  end

  // A master has at most one response in flight, so no two targets collide
  always_comb begin
    for (int m = 0; m < `OBI_NMASTER; m++) begin
      mst_resp_o[m] = '0;
      for (int t = 0; t < `OBI_NTARGET; t++) begin
        if (arb_gnt[t][m] && tgt_resp_i[t].gnt) begin
          mst_resp_o[m].gnt = 1'b1;
        end
        if (tgt_resp_i[t].rvalid && (owner_q[t] == mst_idx_t'(m))) begin
          mst_resp_o[m].rvalid = 1'b1;
          mst_resp_o[m].rdata  = tgt_resp_i[t].rdata;
        end
      end
    end
  end

endmodule

// File: source/obi_rr_arbiter.sv
// Round-robin arbiter for one target port of the crossbar
// Grant is combinational, the priority pointer moves on each grant
`timescale 1ns/1ps
`include "obi_settings.svh"

module obi_rr_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [`OBI_NMASTER-1:0] req_i,
  output logic [`OBI_NMASTER-1:0] gnt_o,
  output obi_pkg::mst_idx_t       sel_o
);
  import obi_pkg::*;

  // Last granted master
  mst_idx_t last_q;
  logic     found;
  int       cand;

  // Search starts just above the last winner and wraps around
  always_comb begin
    found = 1'b0;
    sel_o = last_q;
    gnt_o = '0;
    cand  = 0;
    for (int off = 1; off <= `OBI_NMASTER; off++) begin
      cand = (int'(last_q) + off) % `OBI_NMASTER;
      if (!found && req_i[cand]) begin
        found = 1'b1;
        sel_o = mst_idx_t'(cand);
      end
    end
    if (found) begin
      gnt_o[sel_o] = 1'b1;
    end
  end

  // Reset to the last master so master 0 wins first
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q <= mst_idx_t'(`OBI_NMASTER - 1);
    end else if (found) begin
      last_q <= sel_o;
    end
  end

endmodule

// File: source/obi_addr_decode.sv
// Address decoder for one master port
// Picks the target index from the fixed address map, error target by default
`timescale 1ns/1ps
`include "obi_settings.svh"

module obi_addr_decode (
  input  obi_pkg::addr_t    addr_i,
  output obi_pkg::tgt_idx_t idx_o
);
  import obi_pkg::*;

  // Offsets into each window, unsigned wrap covers addresses below base
  addr_t off_sram0;
  addr_t off_sram1;

  assign off_sram0 = addr_i - `OBI_SRAM0_BASE;
  assign off_sram1 = addr_i - `OBI_SRAM1_BASE;

  always_comb begin
    if (off_sram0 < `OBI_SRAM_SIZE) begin
      idx_o = tgt_idx_t'(0);
    end else if (off_sram1 < `OBI_SRAM_SIZE) begin
      idx_o = tgt_idx_t'(1);
    end else begin
      // Unclaimed address
      idx_o = tgt_idx_t'(`OBI_ERROR_IDX);
    end
  end

endmodule

// File: source/obi_pkg.sv
// Shared types for the OBI crossbar and its targets
// Modules import this for request, response and index types

package obi_pkg;

  // Byte address and data word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // One enable per byte lane
  typedef logic [3:0] be_t;

  // Port indices
  typedef logic [1:0] mst_idx_t;
  typedef logic [1:0] tgt_idx_t;

  // Master to target, 70 bits
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  // Target to master, 34 bits
  // rvalid comes one cycle after the accepted request
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_resp_t;

endpackage

// File: source/obi_settings.svh
// Fixed bus configuration for the system interconnect
// Include in any file that needs port counts or the address map
`ifndef OBI_SETTINGS_SVH
`define OBI_SETTINGS_SVH

// Port counts
`define OBI_NMASTER 3
`define OBI_NTARGET 3

// SRAM bank depth in 32-bit words
`define OBI_SRAM_WORDS 1024

// Address map, byte addresses
`define OBI_SRAM0_BASE 32'h0000_0000
`define OBI_SRAM1_BASE 32'h0001_0000
// 4 KiB window per bank
`define OBI_SRAM_SIZE 32'h0000_1000

// Default target for unmapped addresses
`define OBI_ERROR_IDX 2
`define OBI_ERROR_RDATA 32'hbadc_0ffe

`endif
